/* scope_acq.f */
src/scope_acq_pkg.sv
src/downsampler.sv
src/trigger_engine.sv
src/sample_ram.sv
src/scope_regs.sv
src/scope_acq_top.sv
dv/scope_checker.sv
dv/scope_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the acquisition testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f scope_acq.f --top-module scope_tb -o scope_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/scope_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "test passed"; then
   exit 0
fi
exit 1

/* dv/scope_tb.sv */
`timescale 1ns/1ps

module scope_tb;

   import scope_acq_pkg::*;

   localparam int NROWS      = 4;
   localparam int POLL_LIMIT = 1000;
   localparam int RDY_LIMIT  = 8;
   localparam int M_IDLE     = 0;
   localparam int M_WAIT     = 1;
   localparam int M_POST     = 2;

   // One test per row
   // xs_src picks the xorshift stream and an ext_delay of 0 leaves ext_trig low
   typedef struct packed {
      logic [15:0] thresh;
      logic [7:0]  post_len;
      logic [2:0]  decim;
      logic        xs_src;
      logic [7:0]  ext_delay;
   } row_t;

   string row_names [NROWS] = '{"ramp_d0", "ramp_rearm", "ramp_d2", "xorshift_ext"};
   row_t  rows [NROWS] = '{
      '{16'd100,   8'd16, 3'd0, 1'b0, 8'd0},
      '{16'hFF38,  8'd40, 3'd0, 1'b0, 8'd0},
      '{16'd100,   8'd32, 3'd2, 1'b0, 8'd0},
      '{16'd511,   8'd20, 3'd0, 1'b1, 8'd6}
   };

   logic             lvds_clk_slow;
   logic             rst_n;
   logic [ADC_W-1:0] adc_word;
   logic             ext_trig;
   logic             trig_out;
   apb_req_t         apb_req;
   apb_rsp_t         apb_rsp;
   logic             xs_src_sel;
   logic             timed_out;
   int unsigned      wave_idx = 0;
   logic [31:0]      xs_state = 32'd55340;

   // Reference model state
   sample_t           mem_m [1 << RAM_AW];
   logic [ADC_W-1:0]  m_word;
   sample_t           m_beat_s;
   sample_t           m_prev;
   sample_t           m_thresh;
   logic              m_beat_v;
   logic              m_have_prev;
   logic              m_arm;
   logic [RAM_AW-1:0] m_ptr;
   logic [RAM_AW-1:0] m_trig_addr;
   int                m_state;
   int                m_grp;
   int                m_dcur;
   int                m_decim;
   int                m_post;
   int                m_post_len;
   int                m_events;

   scope_acq_top scope_acq_top_i (
      .lvds_clk_slow (lvds_clk_slow),
      .rst_n         (rst_n),
      .adc_word      (adc_word),
      .ext_trig      (ext_trig),
      .trig_out      (trig_out),
      .apb_req       (apb_req),
      .apb_rsp       (apb_rsp)
   );

   scope_checker checker_i (
      .lvds_clk_slow (lvds_clk_slow),
      .rst_n         (rst_n),
      .apb_req       (apb_req),
      .apb_rsp       (apb_rsp),
      .trig_out      (trig_out)
   );

   initial begin
      lvds_clk_slow = 1'b0;
      forever #10 lvds_clk_slow = ~lvds_clk_slow;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ADC source where the ramp follows the cycle index
   always @(negedge lvds_clk_slow) begin
      wave_idx = wave_idx + 1;
      xs_state = xorshift32(xs_state);
      adc_word = xs_src_sel ? xs_state[ADC_W-1:0] : wave_idx[ADC_W-1:0];
   end

   // Cycle model of the acquisition path that updates the last stage first
   always @(posedge lvds_clk_slow or negedge rst_n) begin
      if (!rst_n) begin
         m_state     = M_IDLE;
         m_ptr       = '0;
         m_trig_addr = '0;
         m_have_prev = 1'b0;
         m_arm       = 1'b0;
         m_beat_v    = 1'b0;
         m_post      = 0;
         m_events    = 0;
         m_thresh    = '0;
         m_post_len  = 16;
         m_decim     = 0;
         m_grp       = 0;
         m_dcur      = 0;
      end else begin
         if (m_arm) begin
            m_state     = M_WAIT;
            m_ptr       = '0;
            m_have_prev = 1'b0;
         end else if (m_state != M_IDLE && m_beat_v) begin
            mem_m[m_ptr] = m_beat_s;
            if (m_state == M_WAIT) begin
               if (ext_trig || (m_have_prev && m_prev < m_thresh && m_beat_s >= m_thresh)) begin
                  m_trig_addr = m_ptr;
                  m_post      = 0;
                  m_state     = M_POST;
               end
               m_have_prev = 1'b1;
            end else begin
               m_post = m_post + 1;
               if (m_post == m_post_len) begin
                  m_state  = M_IDLE;
                  m_events = m_events + 1;
               end
            end
            m_prev = m_beat_s;
            m_ptr  = m_ptr + 1'b1;
         end
         // Keep the first word of each group and invert its MSB
         m_beat_v = (m_grp == 0);
         m_beat_s = {~m_word[ADC_W-1], m_word[ADC_W-2:0]};
         m_word   = adc_word;
         if (m_grp >= (1 << m_dcur) - 1) begin
            m_grp  = 0;
            m_dcur = m_decim;
         end else begin
            m_grp = m_grp + 1;
         end
         m_arm = 1'b0;
         if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
            case (apb_req.paddr)
               REG_CTRL:    m_arm = apb_req.pwdata[0];
               REG_THRESH:  m_thresh = apb_req.pwdata[ADC_W-1:0];
               REG_POSTLEN: m_post_len = int'(apb_req.pwdata[7:0]);
               REG_DECIM:   m_decim = (apb_req.pwdata > DECIM_MAX) ? DECIM_MAX : int'(apb_req.pwdata);
               default: ;
            endcase
         end
      end
   end

   task automatic apb_access(input logic wr, input logic [11:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int   waits;
      logic got;
      rdata = '0;
      waits = 0;
      got   = 1'b0;
      if (timed_out) return;
      @(negedge lvds_clk_slow);
      apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      @(negedge lvds_clk_slow);
      apb_req.penable = 1'b1;
      while (!got && waits < RDY_LIMIT) begin
         @(posedge lvds_clk_slow);
         if (apb_rsp.pready) begin
            got   = 1'b1;
            rdata = apb_rsp.prdata;
         end
         waits++;
      end
      @(negedge lvds_clk_slow);
      apb_req = '0;
      if (!got) begin
         checker_i.note_timeout($sformatf("APB access to 0x%03h never saw pready", addr));
         timed_out = 1'b1;
      end
   endtask

   task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      apb_access(1'b1, addr, data, unused);
   endtask

   task automatic check_read(input string name, input logic [11:0] addr,
                             input logic [31:0] exp, input logic [31:0] mask, input logic err);
      logic [31:0] rd;
      checker_i.expect_read(name, exp, mask, err);
      apb_access(1'b0, addr, '0, rd);
   endtask

   task automatic wait_for_done(input string name);
      int          polls;
      logic [31:0] st;
      polls = 0;
      st    = '0;
      while (!st[1] && polls < POLL_LIMIT && !timed_out) begin
         checker_i.expect_read(name, '0, '0, 1'b0);
         apb_access(1'b0, REG_STATUS, '0, st);
         polls++;
      end
      if (!st[1] && !timed_out) begin
         checker_i.note_timeout($sformatf("%s never reported done", name));
         timed_out = 1'b1;
      end
   endtask

   task automatic run_row(input int idx);
      string             nm;
      row_t              r;
      logic [RAM_AW-1:0] a;
      nm = row_names[idx];
      r  = rows[idx];
      xs_src_sel = r.xs_src;
      write_reg(REG_THRESH, 32'(signed'(r.thresh)));
      write_reg(REG_POSTLEN, 32'(r.post_len));
      write_reg(REG_DECIM, 32'(r.decim));
      write_reg(REG_CTRL, 32'h1);
      // Armed and the previous done cleared
      check_read(nm, REG_STATUS, 32'h1, 32'h3, 1'b0);
      if (r.ext_delay != 0) begin
         repeat (r.ext_delay) @(negedge lvds_clk_slow);
         ext_trig = 1'b1;
         @(negedge lvds_clk_slow);
         ext_trig = 1'b0;
      end
      wait_for_done(nm);
      check_read(nm, REG_STATUS, (32'(m_trig_addr) << 16) | 32'h2, '1, 1'b0);
      check_read(nm, REG_EVCNT, 32'(m_events), '1, 1'b0);
      for (int n = 0; n <= int'(r.post_len); n++) begin
         a = m_trig_addr + RAM_AW'(n);
         check_read(nm, RAM_BASE + {2'b00, a, 2'b00}, 32'(mem_m[a]), '1, 1'b0);
      end
      checker_i.check_pulses(nm, 1);
   endtask

   initial begin
      rst_n      = 1'b0;
      apb_req    = '0;
      ext_trig   = 1'b0;
      adc_word   = '0;
      xs_src_sel = 1'b0;
      timed_out  = 1'b0;
      repeat (5) @(posedge lvds_clk_slow);
      @(negedge lvds_clk_slow);
      rst_n = 1'b1;
      check_read("reset_status", REG_STATUS, 32'h0, '1, 1'b0);
      check_read("reset_evcnt", REG_EVCNT, 32'h0, '1, 1'b0);
      check_read("reset_thresh", REG_THRESH, 32'h0, '1, 1'b0);
      check_read("reset_postlen", REG_POSTLEN, 32'd16, '1, 1'b0);
      check_read("reset_decim", REG_DECIM, 32'h0, '1, 1'b0);
      check_read("unmapped", 12'h020, 32'h0, 32'h0, 1'b1);
      checker_i.check_pulses("reset", 0);
      write_reg(REG_THRESH, 32'hFFFF_FFB3);
      check_read("thresh_rw", REG_THRESH, 32'hFFFF_FFB3, '1, 1'b0);
      write_reg(REG_POSTLEN, 32'd200);
      check_read("postlen_rw", REG_POSTLEN, 32'd200, '1, 1'b0);
      write_reg(REG_DECIM, 32'd7);
      check_read("decim_sat", REG_DECIM, 32'(DECIM_MAX), '1, 1'b0);
      for (int i = 0; i < NROWS; i++) begin
         if (!timed_out) begin
            run_row(i);
         end
      end
      $display("checks: %0d  errors: %0d", checker_i.total_checks(), checker_i.total_errors());
      if (checker_i.total_errors() == 0 && !timed_out) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* dv/scope_checker.sv */
`timescale 1ns/1ps

module scope_checker (
   input logic                    lvds_clk_slow,
   input logic                    rst_n,
   input scope_acq_pkg::apb_req_t apb_req,
   input scope_acq_pkg::apb_rsp_t apb_rsp,
   input logic                    trig_out
);

   import scope_acq_pkg::*;

   // Expected read results in the order the reads are issued
   string       name_q [$];
   logic [31:0] value_q [$];
   logic [31:0] mask_q [$];
   logic        err_q [$];

   int          bus_checks = 0;
   int          bus_errors = 0;
   int          call_checks = 0;
   int          call_errors = 0;
   int          pulses = 0;
   int          pulse_mark = 0;
   int          acc_waits = 0;
   int          exp_waits;
   logic        in_access;

   string       cur_name;
   logic [31:0] cur_value;
   logic [31:0] cur_mask;
   logic        cur_err;

   task automatic expect_read(input string name, input logic [31:0] value,
                              input logic [31:0] mask, input logic err);
      name_q.push_back(name);
      value_q.push_back(value);
      mask_q.push_back(mask);
      err_q.push_back(err);
   endtask

   // Pulses since the previous call
   task automatic check_pulses(input string name, input int expected);
      int got;
      got        = pulses - pulse_mark;
      pulse_mark = pulses;
      call_checks++;
      if (got != expected) begin
         call_errors++;
         $display("[FAIL] %s trig_out pulses expected %0d actual %0d", name, expected, got);
      end
   endtask

   task automatic note_timeout(input string what);
      call_errors++;
      $display("Timeout: %s", what);
   endtask

   function automatic int total_checks();
      return bus_checks + call_checks;
   endfunction

   function automatic int total_errors();
      return bus_errors + call_errors;
   endfunction

   // RAM entries sit at 4-byte steps above RAM_BASE
   function automatic logic in_ram_window(input logic [11:0] addr);
      return (int'(addr) >= int'(RAM_BASE)) &&
             (int'(addr) < int'(RAM_BASE) + 4 * (1 << RAM_AW));
   endfunction

   always @(posedge lvds_clk_slow) begin
      if (rst_n && trig_out) begin
         pulses++;
      end
      in_access = apb_req.psel && apb_req.penable;
      // Responses belong to the completing access cycle only
      if (rst_n && ((apb_rsp.pready && !in_access) ||
                    (apb_rsp.pslverr && !apb_rsp.pready))) begin
         bus_errors++;
         $display("APB pready or pslverr high outside a completing access at 0x%03h",
                  apb_req.paddr);
      end
      // Registers answer in the first access cycle and the RAM window in the second
      if (rst_n && in_access && !apb_rsp.pready) begin
         acc_waits++;
      end else if (rst_n && in_access) begin
         exp_waits = in_ram_window(apb_req.paddr) ? 1 : 0;
         if (acc_waits != exp_waits) begin
            bus_errors++;
            $display("APB access to 0x%03h took %0d wait states instead of %0d",
                     apb_req.paddr, acc_waits, exp_waits);
         end
         acc_waits = 0;
      end else begin
         acc_waits = 0;
      end
      // Transfer completes on an access cycle with pready
      if (rst_n && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
         if (apb_req.pwrite) begin
            if (apb_rsp.pslverr) begin
               bus_errors++;
               $display("Unexpected pslverr on APB write to 0x%03h", apb_req.paddr);
            end
         end else if (name_q.size() == 0) begin
            bus_errors++;
            $display("APB read of 0x%03h completed with no expected value", apb_req.paddr);
         end else begin
            cur_name  = name_q.pop_front();
            cur_value = value_q.pop_front();
            cur_mask  = mask_q.pop_front();
            cur_err   = err_q.pop_front();
            bus_checks++;
            if (apb_rsp.pslverr && !cur_err) begin
               bus_errors++;
               $display("Unexpected pslverr on APB read of 0x%03h in %s",
                        apb_req.paddr, cur_name);
            end else if (apb_rsp.pslverr !== cur_err) begin
               bus_errors++;
               $display("[FAIL] %s pslverr at 0x%03h expected %0b actual %0b",
                        cur_name, apb_req.paddr, cur_err, apb_rsp.pslverr);
            end else if (((apb_rsp.prdata ^ cur_value) & cur_mask) !== 32'b0) begin
               bus_errors++;
               $display("[FAIL] %s read 0x%03h expected 0x%08h actual 0x%08h",
                        cur_name, apb_req.paddr, cur_value, apb_rsp.prdata);
            end
         end
      end
   end

endmodule

/* src/scope_acq_top.sv */
`timescale 1ns/1ps

module scope_acq_top #(
   parameter int ram_aw = scope_acq_pkg::RAM_AW
) (
   input  logic                            lvds_clk_slow,
   input  logic                            rst_n,
   input  logic [scope_acq_pkg::ADC_W-1:0] adc_word,
   input  logic                            ext_trig,
   output logic                            trig_out,
   input  scope_acq_pkg::apb_req_t          apb_req,
   output scope_acq_pkg::apb_rsp_t          apb_rsp
);

   import scope_acq_pkg::*;

   sample_beat_t      beat;
   ram_wr_t           ram_wr;
   acq_cfg_t          cfg;
   acq_status_t       status;
   logic              arm;
   logic [ram_aw-1:0] rd_addr;
   sample_t           rd_data;

   // Front end, one ADC word per clock
   downsampler downsampler_i (
      .lvds_clk_slow (lvds_clk_slow),
      .rst_n         (rst_n),
      .adc_word      (adc_word),
      .cfg           (cfg),
      .beat          (beat)
   );

   trigger_engine #(
      .ram_aw (ram_aw)
   ) trigger_engine_i (
      .lvds_clk_slow (lvds_clk_slow),
      .rst_n         (rst_n),
      .beat          (beat),
      .cfg           (cfg),
      .arm           (arm),
      .ext_trig      (ext_trig),
      .wr            (ram_wr),
      .status        (status),
      .trig_out      (trig_out)
   );

   sample_ram #(
      .ram_aw (ram_aw)
   ) sample_ram_i (
      .lvds_clk_slow (lvds_clk_slow),
      .wr            (ram_wr),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data)
   );

   // Host side, also owns the RAM read port
   scope_regs #(
      .ram_aw (ram_aw)
   ) scope_regs_i (
      .lvds_clk_slow (lvds_clk_slow),
      .rst_n         (rst_n),
      .apb_req       (apb_req),
      .apb_rsp       (apb_rsp),
      .cfg           (cfg),
      .arm           (arm),
      .status        (status),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data)
   );

endmodule

/* src/scope_regs.sv */
`timescale 1ns/1ps

module scope_regs #(
   parameter int ram_aw = scope_acq_pkg::RAM_AW
) (
   input  logic                      lvds_clk_slow,
   input  logic                      rst_n,
   input  scope_acq_pkg::apb_req_t    apb_req,
   output scope_acq_pkg::apb_rsp_t    apb_rsp,
   output scope_acq_pkg::acq_cfg_t    cfg,
   output logic                      arm,
   input  scope_acq_pkg::acq_status_t status,
   output logic [ram_aw-1:0]         rd_addr,
   input  scope_acq_pkg::sample_t     rd_data
);

   import scope_acq_pkg::*;

   // First byte address past the RAM window
   localparam int RAM_END = int'(RAM_BASE) + (4 << ram_aw);

   acq_cfg_t    cfg_q;
   logic        access;
   logic        is_ram;
   logic        is_reg;
   logic        ram_wait;
   logic        ready;
   logic        err;
   logic        wr_fire;
   logic [31:0] rdata;

   function automatic logic [31:0] sext(sample_t s);
      return {{(32 - ADC_W){s[ADC_W-1]}}, s};
   endfunction

   assign access  = apb_req.psel && apb_req.penable;
   assign is_ram  = (apb_req.paddr >= RAM_BASE) && (int'(apb_req.paddr) < RAM_END);
   assign rd_addr = apb_req.paddr[ram_aw+1:2];

   // Register decode and read mux
   always_comb begin
      is_reg = 1'b1;
      rdata  = '0;
      case (apb_req.paddr)
         REG_CTRL:    rdata = '0;
         REG_THRESH:  rdata = sext(cfg_q.thresh);
         REG_POSTLEN: rdata = {24'b0, cfg_q.post_len};
         REG_DECIM:   rdata = {29'b0, cfg_q.decim};
         REG_STATUS: begin
            rdata[0]             = status.armed;
            rdata[1]             = status.done;
            rdata[16 +: RAM_AW]  = status.trig_addr;
         end
         REG_EVCNT:   rdata = status.event_count;
         default: begin
            is_reg = 1'b0;
            rdata  = sext(rd_data);
         end
      endcase
   end

   // RAM accesses complete one cycle later than registers
   assign ready = access && (!is_ram || ram_wait);

   // RAM window is read only
   assign err     = ready && (!(is_reg || is_ram) || (apb_req.pwrite && is_ram));
   assign wr_fire = ready && apb_req.pwrite && is_reg;

   always_ff @(posedge lvds_clk_slow or negedge rst_n) begin
      if (!rst_n) begin
         ram_wait <= 1'b0;
         arm      <= 1'b0;
         cfg_q    <= '{thresh: '0, post_len: 8'd16, decim: '0};
      end else begin
         ram_wait <= access && is_ram && !ram_wait;
         arm      <= wr_fire && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
         if (wr_fire) begin
            case (apb_req.paddr)
               REG_THRESH:  cfg_q.thresh   <= apb_req.pwdata[ADC_W-1:0];
               REG_POSTLEN: cfg_q.post_len <= apb_req.pwdata[7:0];
               REG_DECIM: begin
                  if (apb_req.pwdata > 32'(DECIM_MAX)) begin
                     cfg_q.decim <= 3'(DECIM_MAX);
                  end else begin
                     cfg_q.decim <= apb_req.pwdata[2:0];
                  end
               end
               default: ;
            endcase
         end
      end
   end

   assign cfg     = cfg_q;
   assign apb_rsp = '{pready: ready,
                      prdata: (ready && !apb_req.pwrite) ? rdata : 32'b0,
                      pslverr: err};

endmodule

/* src/sample_ram.sv */
`timescale 1ns/1ps

module sample_ram #(
   parameter int ram_aw = scope_acq_pkg::RAM_AW
) (
   input  logic                   lvds_clk_slow,
   input  scope_acq_pkg::ram_wr_t wr,
   input  logic [ram_aw-1:0]      rd_addr,
   output scope_acq_pkg::sample_t rd_data
);

   import scope_acq_pkg::*;

   localparam int DEPTH = 1 << ram_aw;

   sample_t mem [DEPTH];

   // Write port from the trigger engine
   always_ff @(posedge lvds_clk_slow) begin
      if (wr.we) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // Registered read for the host window
   always_ff @(posedge lvds_clk_slow) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* src/trigger_engine.sv */
`timescale 1ns/1ps

module trigger_engine #(
   parameter int ram_aw = scope_acq_pkg::RAM_AW
) (
   input  logic                       lvds_clk_slow,
   input  logic                       rst_n,
   input  scope_acq_pkg::sample_beat_t beat,
   input  scope_acq_pkg::acq_cfg_t     cfg,
   input  logic                       arm,
   input  logic                       ext_trig,
   output scope_acq_pkg::ram_wr_t      wr,
   output scope_acq_pkg::acq_status_t  status,
   output logic                       trig_out
);

   import scope_acq_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT,
      ST_POST
   } state_t;

   state_t            state;
   sample_t           cur_s;
   sample_t           prev_s;
   sample_t           thresh_s;
   logic              have_prev;
   logic              wr_en;
   logic              trig_hit;
   logic              last_post;
   logic [ram_aw-1:0] wr_ptr;
   logic [ram_aw-1:0] trig_addr;
   logic [7:0]        post_cnt;
   logic              done_q;
   logic [31:0]       ev_cnt;

   assign cur_s    = beat.data;
   assign thresh_s = cfg.thresh;

   // Every kept sample is stored while a capture is running
   assign wr_en = (state != ST_IDLE) && beat.valid && !arm;

   // Rising crossing needs a previous sample from this capture
   assign trig_hit = (state == ST_WAIT) && beat.valid && !arm &&
                     (ext_trig || (have_prev && (prev_s < thresh_s) && (cur_s >= thresh_s)));

   assign last_post = (state == ST_POST) && beat.valid && (post_cnt == cfg.post_len - 8'd1);

   always_ff @(posedge lvds_clk_slow or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         wr_ptr    <= '0;
         trig_addr <= '0;
         post_cnt  <= '0;
         have_prev <= 1'b0;
         done_q    <= 1'b0;
         ev_cnt    <= '0;
      end else if (arm) begin
         state     <= ST_WAIT;
         wr_ptr    <= '0;
         have_prev <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         case (state)
            ST_WAIT: begin
               if (trig_hit) begin
                  trig_addr <= wr_ptr;
                  post_cnt  <= '0;
                  state     <= ST_POST;
               end else if (beat.valid) begin
                  have_prev <= 1'b1;
               end
            end
            ST_POST: begin
               if (last_post) begin
                  state  <= ST_IDLE;
                  done_q <= 1'b1;
                  ev_cnt <= ev_cnt + 1'b1;
               end else if (beat.valid) begin
                  post_cnt <= post_cnt + 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

   // Previous written sample for the crossing test
   always_ff @(posedge lvds_clk_slow) begin
      if (wr_en) begin
         prev_s <= cur_s;
      end
   end

   assign wr       = '{we: wr_en, addr: wr_ptr, data: cur_s};
   assign trig_out = trig_hit;
   assign status   = '{armed: (state != ST_IDLE), done: done_q,
                       trig_addr: trig_addr, event_count: ev_cnt};

endmodule

/* src/downsampler.sv */
`timescale 1ns/1ps

module downsampler (
   input  logic                            lvds_clk_slow,
   input  logic                            rst_n,
   input  logic [scope_acq_pkg::ADC_W-1:0] adc_word,
   input  scope_acq_pkg::acq_cfg_t         cfg,
   output scope_acq_pkg::sample_beat_t     beat
);

   import scope_acq_pkg::*;

   localparam int CNT_W = DECIM_MAX;

   logic [ADC_W-1:0] adc_q;
   logic [CNT_W-1:0] grp_cnt;
   logic [2:0]       decim_cur;
   logic             grp_last;
   logic             beat_valid;
   sample_t          beat_data;

   // Input capture register for the LVDS word
   always_ff @(posedge lvds_clk_slow) begin
      adc_q <= adc_word;
   end

   // Last sample of the current group of 2**decim_cur
   assign grp_last = (grp_cnt == CNT_W'((1 << decim_cur) - 1));

   always_ff @(posedge lvds_clk_slow or negedge rst_n) begin
      if (!rst_n) begin
         grp_cnt    <= '0;
         decim_cur  <= '0;
         beat_valid <= 1'b0;
      end else begin
         // Keep the first sample of each group
         beat_valid <= (grp_cnt == '0);
         if (grp_last) begin
            grp_cnt   <= '0;
            // New exponent only takes hold at a group boundary
            decim_cur <= cfg.decim;
         end else begin
            grp_cnt <= grp_cnt + 1'b1;
         end
      end
   end

   // Offset binary to two's complement
   always_ff @(posedge lvds_clk_slow) begin
      beat_data <= {~adc_q[ADC_W-1], adc_q[ADC_W-2:0]};
   end

   assign beat = '{valid: beat_valid, data: beat_data};

endmodule

/* src/scope_acq_pkg.sv */
package scope_acq_pkg;

   // Raw ADC word width, offset binary
   localparam int ADC_W = 10;

   // Capture memory depth is 2**RAM_AW entries
   localparam int RAM_AW = 8;

   // Largest decimation exponent (group of 16 samples)
   localparam int DECIM_MAX = 4;

   // APB byte addresses
   localparam logic [11:0] REG_CTRL    = 12'h000;
   localparam logic [11:0] REG_THRESH  = 12'h004;
   localparam logic [11:0] REG_POSTLEN = 12'h008;
   localparam logic [11:0] REG_DECIM   = 12'h00C;
   localparam logic [11:0] REG_STATUS  = 12'h010;
   localparam logic [11:0] REG_EVCNT   = 12'h014;
   localparam logic [11:0] RAM_BASE    = 12'h400;

   typedef logic signed [ADC_W-1:0] sample_t;

   typedef struct packed {
      logic    valid;
      sample_t data;
   } sample_beat_t;

   typedef struct packed {
      logic              we;
      logic [RAM_AW-1:0] addr;
      sample_t           data;
   } ram_wr_t;

   typedef struct packed {
      sample_t    thresh;
      logic [7:0] post_len;
      logic [2:0] decim;
   } acq_cfg_t;

   typedef struct packed {
      logic              armed;
      logic              done;
      logic [RAM_AW-1:0] trig_addr;
      logic [31:0]       event_count;
   } acq_status_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [11:0] paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic        pready;
      logic [31:0] prdata;
      logic        pslverr;
   } apb_rsp_t;

endpackage
